// ==== Bender.yml ====
package:
  name: lite_core

sources:
  - files:
      - rtl/core_pkg.sv
      - rtl/pipe_ifs.sv
      - rtl/pipe_ctrl.sv
      - rtl/fetch_stage.sv
      - rtl/regfile.sv
      - rtl/decode_stage.sv
      - rtl/execute_stage.sv
      - rtl/writeback_stage.sv
      - rtl/lite_core.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_core.sv

// ==== flist.f ====
+incdir+sim
rtl/core_pkg.sv
rtl/pipe_ifs.sv
rtl/pipe_ctrl.sv
rtl/fetch_stage.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/lite_core.sv
sim/tb_core.sv

// ==== rtl/core_pkg.sv ====
package core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h1c000000;

    // 3R format, opcode in [31:15]
    localparam logic [31:0] opc_add_w = 32'h00100000;
    localparam logic [31:0] opc_sub_w = 32'h00110000;
    localparam logic [31:0] opc_slt   = 32'h00120000;
    localparam logic [31:0] opc_and   = 32'h00148000;
    localparam logic [31:0] opc_or    = 32'h00150000;
    localparam logic [31:0] opc_xor   = 32'h00158000;

    // 2RI12, opcode in [31:22]
    localparam logic [31:0] opc_addi_w = 32'h02800000;

    // 1RI20, opcode in [31:25]
    localparam logic [31:0] opc_lu12i_w = 32'h14000000;

    // 2RI16 branches, opcode in [31:26]
    localparam logic [31:0] opc_beq = 32'h58000000;
    localparam logic [31:0] opc_bne = 32'h5c000000;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne
    } br_op_e;

    typedef enum logic [1:0] {
        fs_idle,
        fs_request,
        fs_wait_resp,
        fs_drop_resp
    } fetch_state_e;

endpackage

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                            clk,
    input  logic                            id_valid,
    input  logic [core_pkg::xlen-1:0]       id_pc,
    input  logic [core_pkg::xlen-1:0]       id_inst,
    input  logic                            rf_we,
    input  logic [core_pkg::reg_addr_w-1:0] rf_waddr,
    input  logic [core_pkg::xlen-1:0]       rf_wdata,
    exe_wb_if.fwd                           exe_wb,
    id_exe_if.drv                           id_exe,
    output logic                            br_taken,
    output logic [core_pkg::xlen-1:0]       br_target
);

    core_pkg::alu_op_e               alu_op;
    core_pkg::br_op_e                br_op;
    logic                            dec_we;
    logic                            use_imm;
    logic [core_pkg::xlen-1:0]       imm;
    logic [core_pkg::xlen-1:0]       si12;
    logic [core_pkg::xlen-1:0]       si20;
    logic [core_pkg::xlen-1:0]       offs;
    logic [core_pkg::reg_addr_w-1:0] rf_raddr1;
    logic [core_pkg::reg_addr_w-1:0] rf_raddr2;
    logic [core_pkg::xlen-1:0]       rf_rdata1;
    logic [core_pkg::xlen-1:0]       rf_rdata2;
    logic [core_pkg::xlen-1:0]       op1;
    logic [core_pkg::xlen-1:0]       op2;

    assign si12 = {{20{id_inst[21]}}, id_inst[21:10]};
    assign si20 = {id_inst[24:5], 12'b0};
    assign offs = {{14{id_inst[25]}}, id_inst[25:10], 2'b00};

    always_comb begin
        alu_op  = core_pkg::alu_add;
        br_op   = core_pkg::br_none;
        dec_we  = 1'b0;
        use_imm = 1'b0;
        imm     = '0;
        if (id_inst[31:15] == core_pkg::opc_add_w[31:15]) begin
            dec_we = 1'b1;
        end else if (id_inst[31:15] == core_pkg::opc_sub_w[31:15]) begin
            alu_op = core_pkg::alu_sub;
            dec_we = 1'b1;
        end else if (id_inst[31:15] == core_pkg::opc_slt[31:15]) begin
            alu_op = core_pkg::alu_slt;
            dec_we = 1'b1;
        end else if (id_inst[31:15] == core_pkg::opc_and[31:15]) begin
            alu_op = core_pkg::alu_and;
            dec_we = 1'b1;
        end else if (id_inst[31:15] == core_pkg::opc_or[31:15]) begin
            alu_op = core_pkg::alu_or;
            dec_we = 1'b1;
        end else if (id_inst[31:15] == core_pkg::opc_xor[31:15]) begin
            alu_op = core_pkg::alu_xor;
            dec_we = 1'b1;
        end else if (id_inst[31:22] == core_pkg::opc_addi_w[31:22]) begin
            dec_we  = 1'b1;
            use_imm = 1'b1;
            imm     = si12;
        end else if (id_inst[31:25] == core_pkg::opc_lu12i_w[31:25]) begin
            alu_op  = core_pkg::alu_lui;
            dec_we  = 1'b1;
            use_imm = 1'b1;
            imm     = si20;
        end else if (id_inst[31:26] == core_pkg::opc_beq[31:26]) begin
            br_op = core_pkg::br_beq;
        end else if (id_inst[31:26] == core_pkg::opc_bne[31:26]) begin
            br_op = core_pkg::br_bne;
        end
    end

    // branches compare rj with rd, 3R ops read rk
    assign rf_raddr1 = id_inst[9:5];
    assign rf_raddr2 = (br_op != core_pkg::br_none) ? id_inst[4:0] : id_inst[14:10];

    regfile regfile_inst (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    // EXE is younger than WB, so it takes priority
    assign op1 = (exe_wb.we && exe_wb.dest == rf_raddr1 && rf_raddr1 != '0) ? exe_wb.result :
                 (rf_we && rf_waddr == rf_raddr1) ? rf_wdata : rf_rdata1;
    assign op2 = (exe_wb.we && exe_wb.dest == rf_raddr2 && rf_raddr2 != '0) ? exe_wb.result :
                 (rf_we && rf_waddr == rf_raddr2) ? rf_wdata : rf_rdata2;

    assign br_taken  = id_valid && ((br_op == core_pkg::br_beq && op1 == op2) ||
                                    (br_op == core_pkg::br_bne && op1 != op2));
    assign br_target = id_pc + offs;

    assign id_exe.pc     = id_pc;
    assign id_exe.alu_op = alu_op;
    assign id_exe.src1   = op1;
    assign id_exe.src2   = use_imm ? imm : op2;
    assign id_exe.dest   = id_inst[4:0];
    assign id_exe.we     = dec_we;

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic  clk,
    input  logic  exe_valid,
    id_exe_if.rcv id_exe,
    exe_wb_if.drv exe_wb
);

    logic [core_pkg::xlen-1:0]       pc_q;
    core_pkg::alu_op_e               op_q;
    logic [core_pkg::xlen-1:0]       src1_q;
    logic [core_pkg::xlen-1:0]       src2_q;
    logic [core_pkg::reg_addr_w-1:0] dest_q;
    logic                            we_q;
    logic [core_pkg::xlen-1:0]       alu_res;

    always_ff @(posedge clk) begin
        pc_q   <= id_exe.pc;
        op_q   <= id_exe.alu_op;
        src1_q <= id_exe.src1;
        src2_q <= id_exe.src2;
        dest_q <= id_exe.dest;
        we_q   <= id_exe.we;
    end

    always_comb begin
        case (op_q)
            core_pkg::alu_add: alu_res = src1_q + src2_q;
            core_pkg::alu_sub: alu_res = src1_q - src2_q;
            core_pkg::alu_and: alu_res = src1_q & src2_q;
            core_pkg::alu_or:  alu_res = src1_q | src2_q;
            core_pkg::alu_xor: alu_res = src1_q ^ src2_q;
            core_pkg::alu_slt: alu_res = {{(core_pkg::xlen-1){1'b0}},
                                          $signed(src1_q) < $signed(src2_q)};
            core_pkg::alu_lui: alu_res = src2_q;
            default:           alu_res = '0;
        endcase
    end

    // bubbles must not forward
    assign exe_wb.pc     = pc_q;
    assign exe_wb.dest   = dest_q;
    assign exe_wb.we     = we_q && exe_valid;
    assign exe_wb.result = alu_res;

endmodule

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      pc_advance,
    input  logic                      id_load,
    input  logic                      br_taken,
    input  logic [core_pkg::xlen-1:0] br_target,
    input  logic [core_pkg::xlen-1:0] inst_rdata,
    output logic [core_pkg::xlen-1:0] inst_addr,
    output logic [core_pkg::xlen-1:0] id_pc,
    output logic [core_pkg::xlen-1:0] id_inst
);

    logic [core_pkg::xlen-1:0] pc;
    logic [core_pkg::xlen-1:0] pc_seq;
    logic [core_pkg::xlen-1:0] pc_nxt;
    logic [core_pkg::xlen-1:0] inflight_pc;

    assign pc_seq = pc + 32'd4;

    // redirect wins over the sequential step
    always_comb begin
        if (br_taken) begin
            pc_nxt = br_target;
        end else if (pc_advance) begin
            pc_nxt = pc_seq;
        end else begin
            pc_nxt = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= core_pkg::reset_pc;
        end else begin
            pc <= pc_nxt;
        end
    end

    // address of the outstanding request
    always_ff @(posedge clk) begin
        if (pc_advance) begin
            inflight_pc <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (id_load) begin
            id_pc   <= inflight_pc;
            id_inst <= inst_rdata;
        end
    end

    assign inst_addr = pc;

endmodule

// ==== rtl/lite_core.sv ====
`timescale 1ns/1ps

module lite_core (
    input  logic                            clk,
    input  logic                            reset,
    // instruction fetch
    output logic                            inst_req_valid,
    input  logic                            inst_req_ready,
    output logic [core_pkg::xlen-1:0]       inst_addr,
    input  logic                            inst_resp_valid,
    input  logic [core_pkg::xlen-1:0]       inst_rdata,
    // trace at write-back
    output logic [core_pkg::xlen-1:0]       debug_wb_pc,
    output logic [3:0]                      debug_wb_rf_we,
    output logic [core_pkg::reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [core_pkg::xlen-1:0]       debug_wb_rf_wdata
);

    logic                            pc_advance;
    logic                            id_load;
    logic                            id_valid;
    logic                            exe_valid;
    logic                            wb_valid;
    logic                            br_taken;
    logic [core_pkg::xlen-1:0]       br_target;
    logic [core_pkg::xlen-1:0]       id_pc;
    logic [core_pkg::xlen-1:0]       id_inst;
    logic                            rf_we;
    logic [core_pkg::reg_addr_w-1:0] rf_waddr;
    logic [core_pkg::xlen-1:0]       rf_wdata;

    id_exe_if id_exe ();
    exe_wb_if exe_wb ();

    pipe_ctrl pipe_ctrl_inst (
        .clk             (clk),
        .reset           (reset),
        .inst_req_ready  (inst_req_ready),
        .inst_resp_valid (inst_resp_valid),
        .br_taken        (br_taken),
        .inst_req_valid  (inst_req_valid),
        .pc_advance      (pc_advance),
        .id_load         (id_load),
        .id_valid        (id_valid),
        .exe_valid       (exe_valid),
        .wb_valid        (wb_valid)
    );

    fetch_stage fetch_stage_inst (
        .clk        (clk),
        .reset      (reset),
        .pc_advance (pc_advance),
        .id_load    (id_load),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .inst_rdata (inst_rdata),
        .inst_addr  (inst_addr),
        .id_pc      (id_pc),
        .id_inst    (id_inst)
    );

    decode_stage decode_stage_inst (
        .clk       (clk),
        .id_valid  (id_valid),
        .id_pc     (id_pc),
        .id_inst   (id_inst),
        .rf_we     (rf_we),
        .rf_waddr  (rf_waddr),
        .rf_wdata  (rf_wdata),
        .exe_wb    (exe_wb.fwd),
        .id_exe    (id_exe.drv),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    execute_stage execute_stage_inst (
        .clk       (clk),
        .exe_valid (exe_valid),
        .id_exe    (id_exe.rcv),
        .exe_wb    (exe_wb.drv)
    );

    writeback_stage writeback_stage_inst (
        .clk               (clk),
        .wb_valid          (wb_valid),
        .exe_wb            (exe_wb.rcv),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

// ==== rtl/pipe_ctrl.sv ====
`timescale 1ns/1ps

module pipe_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic inst_req_ready,
    input  logic inst_resp_valid,
    input  logic br_taken,
    output logic inst_req_valid,
    output logic pc_advance,
    output logic id_load,
    output logic id_valid,
    output logic exe_valid,
    output logic wb_valid
);

    core_pkg::fetch_state_e state;
    core_pkg::fetch_state_e state_nxt;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= core_pkg::fs_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            core_pkg::fs_idle: begin
                state_nxt = core_pkg::fs_request;
            end
            core_pkg::fs_request: begin
                // accepted slot is wrong path if a branch redirects now
                if (inst_req_ready) begin
                    state_nxt = br_taken ? core_pkg::fs_drop_resp : core_pkg::fs_wait_resp;
                end
            end
            core_pkg::fs_wait_resp: begin
                if (inst_resp_valid) begin
                    state_nxt = core_pkg::fs_request;
                end
            end
            core_pkg::fs_drop_resp: begin
                if (inst_resp_valid) begin
                    state_nxt = core_pkg::fs_request;
                end
            end
            default: state_nxt = core_pkg::fs_idle;
        endcase
    end

    assign inst_req_valid = (state == core_pkg::fs_request);
    assign pc_advance     = inst_req_valid && inst_req_ready;
    assign id_load        = inst_resp_valid && (state == core_pkg::fs_wait_resp);

    // later stages never stall
    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid  <= 1'b0;
            exe_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            id_valid  <= id_load;
            exe_valid <= id_valid;
            wb_valid  <= exe_valid;
        end
    end

endmodule

// ==== rtl/pipe_ifs.sv ====
`timescale 1ns/1ps

interface id_exe_if;
    logic [core_pkg::xlen-1:0]       pc;
    core_pkg::alu_op_e               alu_op;
    logic [core_pkg::xlen-1:0]       src1;
    logic [core_pkg::xlen-1:0]       src2;
    logic [core_pkg::reg_addr_w-1:0] dest;
    logic                            we;

    modport drv (output pc, alu_op, src1, src2, dest, we);
    modport rcv (input pc, alu_op, src1, src2, dest, we);
endinterface

interface exe_wb_if;
    logic [core_pkg::xlen-1:0]       pc;
    logic [core_pkg::reg_addr_w-1:0] dest;
    logic                            we;
    logic [core_pkg::xlen-1:0]       result;

    modport drv (output pc, dest, we, result);
    modport rcv (input pc, dest, we, result);
    // EXE result seen by decode
    modport fwd (input dest, we, result);
endinterface

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                            clk,
    input  logic [core_pkg::reg_addr_w-1:0] raddr1,
    input  logic [core_pkg::reg_addr_w-1:0] raddr2,
    input  logic                            we,
    input  logic [core_pkg::reg_addr_w-1:0] waddr,
    input  logic [core_pkg::xlen-1:0]       wdata,
    output logic [core_pkg::xlen-1:0]       rdata1,
    output logic [core_pkg::xlen-1:0]       rdata2
);

    logic [core_pkg::xlen-1:0] regs [0:(1 << core_pkg::reg_addr_w)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== rtl/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage (
    input  logic                            clk,
    input  logic                            wb_valid,
    exe_wb_if.rcv                           exe_wb,
    output logic                            rf_we,
    output logic [core_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [core_pkg::xlen-1:0]       rf_wdata,
    output logic [core_pkg::xlen-1:0]       debug_wb_pc,
    output logic [3:0]                      debug_wb_rf_we,
    output logic [core_pkg::reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [core_pkg::xlen-1:0]       debug_wb_rf_wdata
);

    logic [core_pkg::xlen-1:0]       pc_q;
    logic [core_pkg::reg_addr_w-1:0] dest_q;
    logic                            we_q;
    logic [core_pkg::xlen-1:0]       result_q;

    always_ff @(posedge clk) begin
        pc_q     <= exe_wb.pc;
        dest_q   <= exe_wb.dest;
        we_q     <= exe_wb.we;
        result_q <= exe_wb.result;
    end

    // writes to r0 are dropped here, also hidden from the trace
    assign rf_we    = wb_valid && we_q && (dest_q != '0);
    assign rf_waddr = dest_q;
    assign rf_wdata = result_q;

    assign debug_wb_pc       = pc_q;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest_q;
    assign debug_wb_rf_wdata = result_q;

endmodule

// ==== sim/isa_model.svh ====
`ifndef isa_model_svh
`define isa_model_svh

// mode 0 alu only on r0..r7, mode 1 dense on r1..r3, mode 2 alu plus forward branches
task automatic gen_program(input int mode);
    int          dense_op [4] = '{0, 1, 5, 7};
    int          op;
    int          reach;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [15:0] offs;
    for (int i = 0; i < prog_words; i++) begin
        rd = 5'($urandom_range(mode == 1 ? 3 : 7, mode == 1 ? 1 : 0));
        rj = 5'($urandom_range(mode == 1 ? 3 : 7, mode == 1 ? 1 : 0));
        rk = 5'($urandom_range(mode == 1 ? 3 : 7, mode == 1 ? 1 : 0));
        op = (mode == 1) ? dense_op[$urandom_range(3)] : $urandom_range(mode == 2 ? 9 : 7);
        if (i < 7) begin
            // give r1..r7 a known value first
            prog[i] = core_pkg::opc_addi_w | {10'd0, 12'($urandom), 5'd0, 5'(i + 1)};
        end else if (i == prog_words - 1) begin
            prog[i] = core_pkg::opc_beq;
        end else begin
            case (op)
                0: prog[i] = core_pkg::opc_add_w | {17'd0, rk, rj, rd};
                1: prog[i] = core_pkg::opc_sub_w | {17'd0, rk, rj, rd};
                2: prog[i] = core_pkg::opc_and | {17'd0, rk, rj, rd};
                3: prog[i] = core_pkg::opc_or | {17'd0, rk, rj, rd};
                4: prog[i] = core_pkg::opc_xor | {17'd0, rk, rj, rd};
                5: prog[i] = core_pkg::opc_slt | {17'd0, rk, rj, rd};
                6: prog[i] = core_pkg::opc_addi_w | {10'd0, 12'($urandom), rj, rd};
                7: prog[i] = core_pkg::opc_lu12i_w | {7'd0, 20'($urandom), rd};
                default: begin
                    // same register half the time so both outcomes show up
                    if ($urandom_range(1) == 1) begin
                        rd = rj;
                    end
                    reach = (prog_words - 1 - i < 8) ? prog_words - 1 - i : 8;
                    offs  = 16'($urandom_range(reach, 1));
                    prog[i] = (op == 8 ? core_pkg::opc_beq : core_pkg::opc_bne) |
                              {6'd0, offs, rj, rd};
                end
            endcase
        end
    end
endtask

// runs prog in order from the reset pc, queues every visible register write
task automatic run_model();
    logic [31:0] regs [0:31];
    logic [31:0] pc;
    logic [31:0] nxt;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [4:0]  rd;
    bit          wr;
    for (int r = 0; r < 32; r++) begin
        regs[r] = '0;
    end
    exp_pc.delete();
    exp_reg.delete();
    exp_val.delete();
    pc = core_pkg::reset_pc;
    for (int step = 0; step < prog_words; step++) begin
        ins = prog[(pc - core_pkg::reset_pc) >> 2];
        if (ins == core_pkg::opc_beq) begin
            break;
        end
        rd  = ins[4:0];
        a   = regs[ins[9:5]];
        b   = regs[ins[14:10]];
        wr  = 1'b1;
        res = '0;
        nxt = pc + 32'd4;
        if (ins[31:26] == core_pkg::opc_beq[31:26] || ins[31:26] == core_pkg::opc_bne[31:26]) begin
            wr = 1'b0;
            if ((a == regs[rd]) == (ins[31:26] == core_pkg::opc_beq[31:26])) begin
                nxt = pc + {{14{ins[25]}}, ins[25:10], 2'b00};
            end
        end else if (ins[31:25] == core_pkg::opc_lu12i_w[31:25]) begin
            res = {ins[24:5], 12'd0};
        end else if (ins[31:22] == core_pkg::opc_addi_w[31:22]) begin
            res = a + {{20{ins[21]}}, ins[21:10]};
        end else begin
            case (ins[31:15])
                core_pkg::opc_add_w[31:15]: res = a + b;
                core_pkg::opc_sub_w[31:15]: res = a - b;
                core_pkg::opc_and[31:15]:   res = a & b;
                core_pkg::opc_or[31:15]:    res = a | b;
                core_pkg::opc_xor[31:15]:   res = a ^ b;
                default:                    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            endcase
        end
        if (wr && rd != 5'd0) begin
            regs[rd] = res;
            exp_pc.push_back(pc);
            exp_reg.push_back(rd);
            exp_val.push_back(res);
        end
        pc = nxt;
    end
endtask

`endif

// ==== sim/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;

    localparam int prog_words   = 256;
    localparam int drive_dly    = 5;
    localparam int drain_cycles = 20;

    logic        clk;
    logic        reset;
    logic        inst_req_valid;
    logic        inst_req_ready;
    logic [31:0] inst_addr;
    logic        inst_resp_valid;
    logic [31:0] inst_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] prog [0:prog_words-1];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_reg [$];
    logic [31:0] exp_val [$];

    bit          mem_on;
    bit          rand_ready;
    int          lat_max;
    bit          trace_on;
    bit          pending;
    int          wait_cnt;
    logic [31:0] pending_addr;
    int          cycles;
    int          errors;
    int          test_err;
    int          tests_clean;
    int          tests_bad;

    `include "isa_model.svh"

    lite_core lite_core_inst (
        .clk               (clk),
        .reset             (reset),
        .inst_req_valid    (inst_req_valid),
        .inst_req_ready    (inst_req_ready),
        .inst_addr         (inst_addr),
        .inst_resp_valid   (inst_resp_valid),
        .inst_rdata        (inst_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [31:0] mem_word(logic [31:0] addr);
        int idx;
        idx = int'((addr - core_pkg::reset_pc) >> 2);
        // only a cancelled fetch goes past the last word
        if (addr < core_pkg::reset_pc || idx >= prog_words) begin
            return core_pkg::opc_beq;
        end
        return prog[idx];
    endfunction

    task automatic check_trace();
        logic [31:0] pc_e;
        logic [4:0]  reg_e;
        logic [31:0] val_e;
        if (debug_wb_rf_we !== 4'b0 && exp_pc.size() == 0) begin
            $display("unexpected register write at %0t: pc %h r%0d", $time, debug_wb_pc,
                     debug_wb_rf_wnum);
            errors++;
        end else if (debug_wb_rf_we !== 4'b0) begin
            pc_e  = exp_pc.pop_front();
            reg_e = exp_reg.pop_front();
            val_e = exp_val.pop_front();
            if (debug_wb_rf_we !== 4'hf || debug_wb_pc !== pc_e ||
                debug_wb_rf_wnum !== reg_e || debug_wb_rf_wdata !== val_e) begin
                $display("Mismatch at %0t: got pc %h r%0d = %h, expected pc %h r%0d = %h",
                         $time, debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                         pc_e, reg_e, val_e);
                errors++;
            end
        end
    endtask

    // memory drives after the rising edge, samples at the falling edge
    initial begin
        forever begin
            @(posedge clk);
            #drive_dly;
            inst_resp_valid = 1'b0;
            if (pending) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    inst_resp_valid = 1'b1;
                    inst_rdata      = mem_word(pending_addr);
                    pending         = 1'b0;
                end
            end
            inst_req_ready = mem_on && (!rand_ready || $urandom_range(1) == 1);
            @(negedge clk);
            cycles++;
            if (reset) begin
                pending = 1'b0;
            end else begin
                if (inst_req_valid && inst_req_ready) begin
                    pending      = 1'b1;
                    pending_addr = inst_addr;
                    wait_cnt     = $urandom_range(lat_max, 1);
                end
                if (trace_on) begin
                    check_trace();
                end
            end
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        #drive_dly;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #drive_dly;
        reset = 1'b0;
    endtask

    task automatic print_counts();
        $display("summary: %0d tests clean, %0d with errors, %0d errors in total",
                 tests_clean, tests_bad, errors);
    endtask

    task automatic end_test(input int num);
        if (errors == test_err) begin
            tests_clean++;
            $display("test %0d done, no errors", num);
        end else begin
            tests_bad++;
            $display("test %0d done, %0d errors", num, errors - test_err);
        end
        test_err = errors;
    endtask

    task automatic run_program(input int num, input int mode, input bit regen,
                               input bit rnd, input int lat);
        int limit;
        if (regen) begin
            gen_program(mode);
        end
        run_model();
        rand_ready = rnd;
        lat_max    = lat;
        mem_on     = 1'b1;
        trace_on   = 1'b1;
        apply_reset();
        limit  = prog_words * 8 + 200;
        cycles = 0;
        while (exp_pc.size() > 0 && cycles < limit) begin
            @(posedge clk);
        end
        if (exp_pc.size() > 0) begin
            $display("test %0d hit the limit of %0d cycles with %0d writes still missing",
                     num, limit, exp_pc.size());
            print_counts();
            $display("TEST FAILED");
            $finish;
        end
        // wrong-path writes would appear here
        repeat (drain_cycles) @(posedge clk);
        trace_on = 1'b0;
        mem_on   = 1'b0;
    endtask

    initial begin
        reset           = 1'b1;
        inst_req_ready  = 1'b0;
        inst_resp_valid = 1'b0;
        inst_rdata      = '0;
        mem_on          = 1'b0;
        rand_ready      = 1'b0;
        lat_max         = 1;
        trace_on        = 1'b0;
        pending         = 1'b0;
        wait_cnt        = 0;
        pending_addr    = '0;
        cycles          = 0;
        errors          = 0;
        test_err        = 0;
        tests_clean     = 0;
        tests_bad       = 0;
        void'($urandom(49));

        // first request after reset, memory silent
        @(posedge clk);
        @(negedge clk);
        if (inst_req_valid !== 1'b0 || debug_wb_rf_we !== 4'b0) begin
            $display("request or register write active during reset at %0t", $time);
            errors++;
        end
        @(posedge clk);
        #drive_dly;
        reset = 1'b0;
        @(posedge clk);
        @(negedge clk);
        if (inst_req_valid !== 1'b1) begin
            $display("no instruction request right after reset at %0t", $time);
            errors++;
        end
        if (inst_addr !== core_pkg::reset_pc) begin
            $display("Mismatch at %0t: first fetch address %h, expected %h", $time,
                     inst_addr, core_pkg::reset_pc);
            errors++;
        end
        repeat (8) begin
            @(negedge clk);
            if (debug_wb_rf_we !== 4'b0) begin
                $display("register write at %0t before any instruction arrived", $time);
                errors++;
            end
        end
        end_test(1);

        run_program(2, 0, 1'b1, 1'b0, 1);
        end_test(2);
        run_program(3, 1, 1'b1, 1'b0, 1);
        end_test(3);
        run_program(4, 2, 1'b1, 1'b0, 1);
        end_test(4);
        // branch program again, then a fresh one, under back-pressure
        run_program(5, 2, 1'b0, 1'b1, 4);
        run_program(5, 2, 1'b1, 1'b1, 4);
        end_test(5);

        print_counts();
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
